// ==== compile.f ====
rtl/rv32i_pkg.sv
rtl/rv32i_regfile.sv
rtl/rv32i_fetch.sv
rtl/rv32i_decode.sv
rtl/rv32i_execute.sv
rtl/rv32i_core.sv
verif/tb_clock_gen.sv
verif/core_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the core testbench with Verilator, pass is decided from the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module core_tb \
  -o sim_core > build.log 2>&1 \
  && ./obj_dir/sim_core > sim.log 2>&1 \
  || echo "simulation or build ended with an error"

cat sim.log 2>/dev/null
grep -q "=== PASS ===" sim.log 2>/dev/null && exit 0 || exit 1

// ==== verif/core_tb.sv ====
// directed testbench for the three-stage RV32I core
// an instruction memory answers each strobe after 1 to 4 cycles,
// an ISA reference model steps the same program in program order
// and every retire of the DUT is compared with the model

`timescale 1ns/100ps

module core_tb;

  localparam int TIMEOUT = 200;               // cycles per wait

  logic                 clk;
  logic                 gen_reset;
  logic                 test_reset = 1'b0;
  logic                 rst;
  rv32i_pkg::word_t     instr = '0;           // memory reply
  logic                 ack = 1'b0;
  rv32i_pkg::word_t     iaddr;
  logic                 stb;
  logic                 ret_valid;
  rv32i_pkg::word_t     ret_pc;
  logic                 ret_we;
  rv32i_pkg::reg_addr_t ret_rd;
  rv32i_pkg::word_t     ret_data;

  rv32i_pkg::word_t     imem [256];
  integer               seed = 32'h34ab;
  int                   prog_len;
  int                   errors = 0;
  rv32i_pkg::word_t     m_regs [32];          // reference model state
  rv32i_pkg::word_t     m_pc;

  assign rst = gen_reset | test_reset;

  tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(8)) u_clk (.o_clk(clk), .o_reset(gen_reset));

  rv32i_core #(.PC_RESET(32'h0)) dut (
    .i_clk (clk), .i_reset (rst), .i_instr (instr), .i_instr_ack (ack),
    .o_iaddr (iaddr), .o_instr_stb (stb), .o_retire_valid (ret_valid),
    .o_retire_pc (ret_pc), .o_retire_we (ret_we), .o_retire_rd (ret_rd),
    .o_retire_data (ret_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // instruction memory model, one request at a time
  ////////////////////////////////////////////////////////////////////////////
  logic             busy = 1'b0;
  logic             fast_mem = 1'b0;          // every reply in the next cycle
  logic [1:0]       cnt = '0;
  rv32i_pkg::word_t addr_q = '0;

  always @(posedge clk) begin : imem_model
    logic [1:0] lat;
    ack <= 1'b0;
    if (rst) begin
      busy <= 1'b0;
    end else if (busy) begin
      if (cnt == 0) begin
        ack   <= 1'b1;
        instr <= imem[addr_q[9:2]];
        busy  <= 1'b0;
      end else begin
        cnt <= cnt - 2'd1;
      end
    end else if (stb) begin
      lat = fast_mem ? 2'd0 : 2'($unsigned($random(seed)) % 4);  // ack 1 to 4 cycles later
      if (lat == 2'd0) begin
        ack   <= 1'b1;                        // reply in the cycle after the strobe
        instr <= imem[iaddr[9:2]];
      end else begin
        busy   <= 1'b1;
        addr_q <= iaddr;
        cnt    <= lat - 2'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // encoders
  ////////////////////////////////////////////////////////////////////////////
  function automatic rv32i_pkg::word_t enc_r(input logic [6:0] f7,
      input rv32i_pkg::reg_addr_t rs2, input rv32i_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input rv32i_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv32i_pkg::word_t enc_i(input logic [11:0] imm,
      input rv32i_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv32i_pkg::reg_addr_t rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic rv32i_pkg::word_t enc_lui(input logic [19:0] imm,
      input rv32i_pkg::reg_addr_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic rv32i_pkg::word_t enc_b(input logic [12:0] off,
      input rv32i_pkg::reg_addr_t rs2, input rv32i_pkg::reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic rv32i_pkg::word_t enc_jal(input logic [20:0] off,
      input rv32i_pkg::reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // ISA reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic rv32i_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
      input logic is_reg, input rv32i_pkg::word_t a, input rv32i_pkg::word_t b);
    case (f3)
      3'd0:    return (is_reg && alt) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? rv32i_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_step(output rv32i_pkg::word_t e_pc, output logic e_we,
      output rv32i_pkg::reg_addr_t e_rd, output rv32i_pkg::word_t e_data);
    rv32i_pkg::word_t w;
    rv32i_pkg::word_t a;
    rv32i_pkg::word_t b;
    rv32i_pkg::word_t nxt;
    w      = imem[m_pc[9:2]];
    a      = m_regs[w[19:15]];
    b      = m_regs[w[24:20]];
    e_pc   = m_pc;
    nxt    = m_pc + 32'd4;
    e_rd   = '0;
    e_data = '0;
    case (w[6:0])
      7'b0110011: begin
        e_rd   = w[11:7];
        e_data = ref_alu(w[14:12], w[30], 1'b1, a, b);
      end
      7'b0010011: begin
        e_rd   = w[11:7];
        e_data = ref_alu(w[14:12], w[30], 1'b0, a, {{20{w[31]}}, w[31:20]});
      end
      7'b0110111: begin
        e_rd   = w[11:7];
        e_data = {w[31:12], 12'b0};
      end
      7'b1100011: begin                       // beq, bne, others do nothing
        if ((w[14:12] == 3'd0 && a == b) || (w[14:12] == 3'd1 && a != b)) begin
          nxt = m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'b1101111: begin
        e_rd   = w[11:7];
        e_data = m_pc + 32'd4;
        nxt    = m_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      default: ;
    endcase
    e_we = (e_rd != '0);
    if (e_we) begin
      m_regs[e_rd] = e_data;
    end
    m_pc = nxt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks and waits
  ////////////////////////////////////////////////////////////////////////////
  task automatic stop_with_fail(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic compare_word(input string what, input rv32i_pkg::word_t got,
      input rv32i_pkg::word_t exp);
    if (got !== exp) begin
      errors++;
      stop_with_fail($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_reg(input string what, input rv32i_pkg::reg_addr_t got,
      input rv32i_pkg::reg_addr_t exp);
    if (got !== exp) begin
      errors++;
      stop_with_fail($sformatf("[FAIL] %0t: %s got x%0d expected x%0d", $time, what, got, exp));
    end
  endtask

  task automatic compare_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      stop_with_fail($sformatf("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic wait_retire();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        stop_with_fail("the core stopped retiring instructions within the timeout");
      end
    end while (!ret_valid);
  endtask

  // clears memory with an address-dependent unsupported opcode (0x7f)
  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[24:0], 7'h7f};
    end
    prog_len = 0;
  endtask

  task automatic put(input rv32i_pkg::word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    test_reset <= 1'b1;
    repeat (3) @(posedge clk);
    test_reset <= 1'b0;
    @(negedge clk);
  endtask

  // resets the core and checks n retires against the model
  task automatic run_program(input int n);
    rv32i_pkg::word_t     e_pc;
    rv32i_pkg::word_t     e_data;
    rv32i_pkg::reg_addr_t e_rd;
    logic                 e_we;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc = 32'h0;
    pulse_reset();
    for (int i = 0; i < n; i++) begin
      model_step(e_pc, e_we, e_rd, e_data);
      wait_retire();
      compare_word("retire pc", ret_pc, e_pc);
      compare_bit("retire we", ret_we, e_we);
      compare_reg("retire rd", ret_rd, e_rd);
      if (e_we) begin
        compare_word("retire data", ret_data, e_data);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_reset_state();
    int n;
    pulse_reset();
    compare_bit("retire valid in reset", ret_valid, 1'b0);
    compare_bit("strobe in reset", stb, 1'b0);
    n = 0;
    while (!stb) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        stop_with_fail("no instruction strobe after reset");
      end
    end
    compare_word("first fetch address", iaddr, 32'h0);
  endtask

  task automatic test_alu_ops();
    clear_program();
    put(enc_i(12'hffb, 5'd0, 3'd0, 5'd1));      // x1 = -5
    put(enc_lui(20'h80000, 5'd2));               // x2 = 0x80000000
    put(enc_i(12'd7, 5'd0, 3'd0, 5'd3));
    put(enc_r(7'h00, 5'd1, 5'd3, 3'd0, 5'd4));   // add
    put(enc_r(7'h20, 5'd1, 5'd3, 3'd0, 5'd5));   // sub, 7 - -5
    put(enc_r(7'h00, 5'd3, 5'd1, 3'd7, 5'd6));
    put(enc_r(7'h00, 5'd3, 5'd1, 3'd6, 5'd7));
    put(enc_r(7'h00, 5'd3, 5'd1, 3'd4, 5'd8));
    put(enc_r(7'h00, 5'd3, 5'd1, 3'd1, 5'd9));
    put(enc_r(7'h00, 5'd3, 5'd2, 3'd5, 5'd10));  // srl
    put(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd11));  // sra on negative
    put(enc_r(7'h00, 5'd3, 5'd1, 3'd2, 5'd12));  // slt -5 < 7
    put(enc_r(7'h00, 5'd3, 5'd1, 3'd3, 5'd13));  // sltu
    put(enc_i(12'h800, 5'd1, 3'd2, 5'd14));      // slti
    put(enc_i(12'h0ff, 5'd1, 3'd3, 5'd15));      // sltiu
    put(enc_i(12'h0f0, 5'd1, 3'd4, 5'd16));
    put(enc_i(12'h00f, 5'd1, 3'd6, 5'd17));
    put(enc_i(12'h0f0, 5'd1, 3'd7, 5'd18));
    put(enc_i(12'h004, 5'd3, 3'd1, 5'd19));      // slli
    put(enc_i(12'h01f, 5'd2, 3'd5, 5'd20));      // srli
    put(enc_i(12'h41f, 5'd2, 3'd5, 5'd21));      // srai
    put(enc_lui(20'habcde, 5'd22));
    run_program(prog_len);
  endtask

  // shortest ack delay, so each read lands in the cycle of the previous write
  task automatic test_dependencies();
    clear_program();
    put(enc_i(12'd3, 5'd0, 3'd0, 5'd1));
    put(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd1));   // reads previous result
    put(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
    put(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));   // x1 from two back
    put(enc_i(12'h7ff, 5'd3, 3'd0, 5'd3));
    put(enc_r(7'h00, 5'd2, 5'd3, 3'd4, 5'd4));
    put(enc_r(7'h00, 5'd4, 5'd3, 3'd6, 5'd5));
    fast_mem = 1'b1;
    run_program(prog_len);
    fast_mem = 1'b0;
  endtask

  task automatic test_branches();
    clear_program();
    put(enc_i(12'd5, 5'd0, 3'd0, 5'd1));
    put(enc_i(12'd5, 5'd0, 3'd0, 5'd2));
    put(enc_b(13'd8, 5'd2, 5'd1, 3'd0));         // beq taken
    put(enc_i(12'd1, 5'd0, 3'd0, 5'd3));         // skipped
    put(enc_b(13'd8, 5'd2, 5'd1, 3'd1));         // bne not taken
    put(enc_b(13'd8, 5'd2, 5'd1, 3'd0));         // beq taken right away
    put(enc_i(12'd2, 5'd0, 3'd0, 5'd4));         // skipped
    put(enc_jal(21'd12, 5'd5));
    put(enc_i(12'd3, 5'd0, 3'd0, 5'd6));         // skipped
    put(enc_i(12'd3, 5'd0, 3'd0, 5'd7));         // skipped
    put(enc_b(13'h1ff8, 5'd0, 5'd5, 3'd1));      // bne back by 8
    run_program(12);
  endtask

  task automatic test_random_program();
    logic [31:0] r;
    logic [2:0]  f3;
    logic        alt;
    clear_program();
    for (int i = 1; i < 32; i++) begin
      r = $random(seed);
      put(enc_i(r[11:0], 5'd0, 3'd0, 5'(i)));
    end
    for (int i = 0; i < 60; i++) begin
      r   = $random(seed);
      f3  = r[2:0];
      alt = r[3] && (f3 == 3'd0 || f3 == 3'd5);
      if (r[4]) begin
        put(enc_r({1'b0, alt, 5'b0}, r[9:5], r[14:10], f3, r[19:15]));
      end else if (f3 == 3'd1 || f3 == 3'd5) begin
        put(enc_i({1'b0, alt, 5'b0, r[24:20]}, r[14:10], f3, r[19:15]));
      end else begin
        put(enc_i(r[31:20], r[14:10], f3, r[19:15]));
      end
    end
    run_program(prog_len);
  endtask

  task automatic test_x0_and_unsupported();
    clear_program();
    put(enc_i(12'd5, 5'd0, 3'd0, 5'd0));         // write to x0
    put(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1));   // x1 = x0 + x0
    put(32'h0000_00ff);                          // unsupported opcode
    put(enc_b(13'd8, 5'd0, 5'd0, 3'd4));         // blt, unsupported here
    put(enc_i(12'd1, 5'd0, 3'd0, 5'd2));
    run_program(prog_len);
  endtask

  initial begin
    int n;
    n = 0;
    while (gen_reset !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        stop_with_fail("power-on reset was never released");
      end
    end
    clear_program();
    test_reset_state();
    test_alu_ops();
    test_dependencies();
    test_branches();
    test_random_program();
    test_x0_and_unsupported();
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verif/tb_clock_gen.sv ====
// clock and power-on reset for the core testbench
// reset is held high for RESET_CYCLES rising edges, then released

`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD       = 100,           // ns
  parameter int RESET_CYCLES = 8
) (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset <= 1'b0;                          // released on a clock edge
  end

endmodule

// ==== rtl/rv32i_core.sv ====
// top level of the three-stage RV32I core
// fetch -> decode -> execute/writeback, with the register file read in decode
// PC_RESET is the address of the first instruction request after reset
// the retire port reports every executed instruction and its register write

`timescale 1ns/100ps

module rv32i_core #(
  parameter rv32i_pkg::word_t PC_RESET = '0
) (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  rv32i_pkg::word_t      i_instr,
  input  logic                  i_instr_ack,
  output rv32i_pkg::word_t      o_iaddr,
  output logic                  o_instr_stb,
  output logic                  o_retire_valid,
  output rv32i_pkg::word_t      o_retire_pc,
  output logic                  o_retire_we,
  output rv32i_pkg::reg_addr_t  o_retire_rd,
  output rv32i_pkg::word_t      o_retire_data
);

  logic                  f_valid;             // fetch to decode
  rv32i_pkg::word_t      f_instr;
  rv32i_pkg::word_t      f_pc;
  logic                  rf_rd_en;            // decode to register file
  rv32i_pkg::reg_addr_t  rf_rs1_addr;
  rv32i_pkg::reg_addr_t  rf_rs2_addr;
  rv32i_pkg::word_t      rs1_data;
  rv32i_pkg::word_t      rs2_data;
  logic                  d_valid;             // decode to execute
  rv32i_pkg::op_class_e  d_class;
  rv32i_pkg::alu_op_e    d_alu_op;
  logic [2:0]            d_funct3;
  rv32i_pkg::reg_addr_t  d_rd;
  rv32i_pkg::reg_addr_t  d_rs1;
  rv32i_pkg::reg_addr_t  d_rs2;
  rv32i_pkg::word_t      d_imm;
  rv32i_pkg::word_t      d_pc;
  logic                  x_redirect;          // execute to fetch and decode
  rv32i_pkg::word_t      x_target;
  logic                  wb_we;               // execute to register file
  rv32i_pkg::reg_addr_t  wb_rd;
  rv32i_pkg::word_t      wb_data;

  assign o_retire_we   = wb_we;
  assign o_retire_rd   = wb_rd;
  assign o_retire_data = wb_data;

  rv32i_fetch #(
    .PC_RESET (PC_RESET)
  ) u_fetch (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_instr     (i_instr),
    .i_instr_ack (i_instr_ack),
    .i_redirect  (x_redirect),
    .i_target    (x_target),
    .o_iaddr     (o_iaddr),
    .o_instr_stb (o_instr_stb),
    .o_valid     (f_valid),
    .o_instr     (f_instr),
    .o_pc        (f_pc)
  );

  rv32i_decode u_decode (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_valid    (f_valid),
    .i_instr    (f_instr),
    .i_pc       (f_pc),
    .i_flush    (x_redirect),
    .o_rf_rd_en (rf_rd_en),
    .o_rs1_addr (rf_rs1_addr),
    .o_rs2_addr (rf_rs2_addr),
    .o_valid    (d_valid),
    .o_class    (d_class),
    .o_alu_op   (d_alu_op),
    .o_funct3   (d_funct3),
    .o_rd       (d_rd),
    .o_rs1      (d_rs1),
    .o_rs2      (d_rs2),
    .o_imm      (d_imm),
    .o_pc       (d_pc)
  );

  rv32i_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rd_en    (rf_rd_en),
    .i_rs1_addr (rf_rs1_addr),
    .i_rs2_addr (rf_rs2_addr),
    .i_we       (wb_we),
    .i_rd       (wb_rd),
    .i_wdata    (wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv32i_execute u_execute (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_valid        (d_valid),
    .i_class        (d_class),
    .i_alu_op       (d_alu_op),
    .i_funct3       (d_funct3),
    .i_rd           (d_rd),
    .i_rs1          (d_rs1),
    .i_rs2          (d_rs2),
    .i_imm          (d_imm),
    .i_pc           (d_pc),
    .i_rs1_data     (rs1_data),
    .i_rs2_data     (rs2_data),
    .o_redirect     (x_redirect),
    .o_target       (x_target),
    .o_wb_we        (wb_we),
    .o_wb_rd        (wb_rd),
    .o_wb_data      (wb_data),
    .o_retire_valid (o_retire_valid),
    .o_retire_pc    (o_retire_pc)
  );

endmodule

// ==== rtl/rv32i_execute.sv ====
// execute and writeback stage of the core
// bypasses its own last result into the operands, runs the alu,
// resolves beq/bne/jal and raises a one-cycle redirect for taken ones
// the result register drives both the register file write and retire

`timescale 1ns/100ps

module rv32i_execute (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_valid,      // decode bundle
  input  rv32i_pkg::op_class_e  i_class,
  input  rv32i_pkg::alu_op_e    i_alu_op,
  input  logic [2:0]            i_funct3,
  input  rv32i_pkg::reg_addr_t  i_rd,
  input  rv32i_pkg::reg_addr_t  i_rs1,
  input  rv32i_pkg::reg_addr_t  i_rs2,
  input  rv32i_pkg::word_t      i_imm,
  input  rv32i_pkg::word_t      i_pc,
  input  rv32i_pkg::word_t      i_rs1_data,   // from register file
  input  rv32i_pkg::word_t      i_rs2_data,
  output logic                  o_redirect,
  output rv32i_pkg::word_t      o_target,
  output logic                  o_wb_we,
  output rv32i_pkg::reg_addr_t  o_wb_rd,
  output rv32i_pkg::word_t      o_wb_data,
  output logic                  o_retire_valid,
  output rv32i_pkg::word_t      o_retire_pc
);

  rv32i_pkg::word_t rs1_val;
  rv32i_pkg::word_t rs2_val;
  rv32i_pkg::word_t op_b;
  rv32i_pkg::word_t alu_y;
  rv32i_pkg::word_t result;
  logic             taken;

  ////////////////////////////////////////////////////////////////////////////
  // operand bypass, o_wb_we is already low for rd 0
  ////////////////////////////////////////////////////////////////////////////
  assign rs1_val = (o_wb_we && o_wb_rd == i_rs1) ? o_wb_data : i_rs1_data;
  assign rs2_val = (o_wb_we && o_wb_rd == i_rs2) ? o_wb_data : i_rs2_data;
  assign op_b    = (i_class == rv32i_pkg::CLS_ALU_IMM) ? i_imm : rs2_val;

  always_comb begin
    case (i_alu_op)
      rv32i_pkg::ADD:  alu_y = rs1_val + op_b;
      rv32i_pkg::SUB:  alu_y = rs1_val - op_b;
      rv32i_pkg::AND:  alu_y = rs1_val & op_b;
      rv32i_pkg::OR:   alu_y = rs1_val | op_b;
      rv32i_pkg::XOR:  alu_y = rs1_val ^ op_b;
      rv32i_pkg::SLL:  alu_y = rs1_val << op_b[4:0];
      rv32i_pkg::SRL:  alu_y = rs1_val >> op_b[4:0];
      rv32i_pkg::SRA:  alu_y = $signed(rs1_val) >>> op_b[4:0];      // keeps sign
      rv32i_pkg::SLT:  alu_y = {31'b0, $signed(rs1_val) < $signed(op_b)};
      rv32i_pkg::SLTU: alu_y = {31'b0, rs1_val < op_b};
      default:         alu_y = rs1_val + op_b;
    endcase
  end

  // result mux by class
  always_comb begin
    case (i_class)
      rv32i_pkg::CLS_LUI: result = i_imm;
      rv32i_pkg::CLS_JAL: result = i_pc + 32'd4;                     // link address
      default:            result = alu_y;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // branch resolution, funct3 bit 0 picks bne over beq
  ////////////////////////////////////////////////////////////////////////////
  assign taken      = i_funct3[0] ? (rs1_val != rs2_val) : (rs1_val == rs2_val);
  assign o_redirect = i_valid && ((i_class == rv32i_pkg::CLS_JAL) ||
                                  (i_class == rv32i_pkg::CLS_BRANCH && taken));
  assign o_target   = i_pc + i_imm;

  ////////////////////////////////////////////////////////////////////////////
  // result / retire register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_retire_valid <= 1'b0;
      o_wb_we        <= 1'b0;
    end else begin
      o_retire_valid <= i_valid;
      o_wb_we        <= i_valid && (i_rd != '0);   // x0 stays zero
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_retire_pc <= i_pc;
      o_wb_rd     <= i_rd;
      o_wb_data   <= result;
    end
  end

  // the redirect must flush decode, so the next cycle has nothing to resolve
  a_redirect_once : assert property (@(posedge i_clk) disable iff (i_reset)
    o_redirect |=> !o_redirect);

endmodule

// ==== rtl/rv32i_decode.sv ====
// decode stage, splits the instruction into fields and builds immediates
// register file addresses go out combinationally with the fetch strobe
// the decoded bundle is registered, so it lines up with the read data
// unsupported opcodes become CLS_NONE and never write a register

`timescale 1ns/100ps

module rv32i_decode (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_valid,      // strobe from fetch
  input  rv32i_pkg::word_t      i_instr,
  input  rv32i_pkg::word_t      i_pc,
  input  logic                  i_flush,      // redirect from execute
  output logic                  o_rf_rd_en,
  output rv32i_pkg::reg_addr_t  o_rs1_addr,
  output rv32i_pkg::reg_addr_t  o_rs2_addr,
  output logic                  o_valid,
  output rv32i_pkg::op_class_e  o_class,
  output rv32i_pkg::alu_op_e    o_alu_op,
  output logic [2:0]            o_funct3,
  output rv32i_pkg::reg_addr_t  o_rd,
  output rv32i_pkg::reg_addr_t  o_rs1,
  output rv32i_pkg::reg_addr_t  o_rs2,
  output rv32i_pkg::word_t      o_imm,
  output rv32i_pkg::word_t      o_pc
);

  rv32i_pkg::opcode_e    opcode;
  rv32i_pkg::op_class_e  cls;
  rv32i_pkg::alu_op_e    alu_op;
  rv32i_pkg::word_t      imm;
  rv32i_pkg::reg_addr_t  rd;
  logic [2:0]            funct3;
  logic                  alt;                 // funct7 bit 5, sub and sra

  assign opcode     = rv32i_pkg::opcode_e'(i_instr[6:0]);
  assign funct3     = i_instr[14:12];
  assign alt        = i_instr[30];
  assign o_rf_rd_en = i_valid;
  assign o_rs1_addr = i_instr[19:15];
  assign o_rs2_addr = i_instr[24:20];

  ////////////////////////////////////////////////////////////////////////////
  // class and immediate
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    cls = rv32i_pkg::CLS_NONE;
    imm = {{20{i_instr[31]}}, i_instr[31:20]};                        // i-type
    case (opcode)
      rv32i_pkg::OPC_OP:     cls = rv32i_pkg::CLS_ALU_REG;
      rv32i_pkg::OPC_OP_IMM: cls = rv32i_pkg::CLS_ALU_IMM;
      rv32i_pkg::OPC_LUI: begin
        cls = rv32i_pkg::CLS_LUI;
        imm = {i_instr[31:12], 12'b0};                                // u-type
      end
      rv32i_pkg::OPC_BRANCH: begin
        if (funct3[2:1] == 2'b00) begin
          cls = rv32i_pkg::CLS_BRANCH;        // beq and bne only
        end
        imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
               i_instr[11:8], 1'b0};                                  // b-type
      end
      rv32i_pkg::OPC_JAL: begin
        cls = rv32i_pkg::CLS_JAL;
        imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
               i_instr[30:21], 1'b0};                                 // j-type
      end
      default: cls = rv32i_pkg::CLS_NONE;
    endcase
  end

  // funct3/funct7 to alu op, subi does not exist so alt only counts for op
  always_comb begin
    case (funct3)
      3'b000:  alu_op = (cls == rv32i_pkg::CLS_ALU_REG && alt) ? rv32i_pkg::SUB
                                                                 : rv32i_pkg::ADD;
      3'b001:  alu_op = rv32i_pkg::SLL;
      3'b010:  alu_op = rv32i_pkg::SLT;
      3'b011:  alu_op = rv32i_pkg::SLTU;
      3'b100:  alu_op = rv32i_pkg::XOR;
      3'b101:  alu_op = alt ? rv32i_pkg::SRA : rv32i_pkg::SRL;
      3'b110:  alu_op = rv32i_pkg::OR;
      default: alu_op = rv32i_pkg::AND;
    endcase
  end

  // branches and no-ops carry rd 0, so execute never writes for them
  assign rd = (cls == rv32i_pkg::CLS_BRANCH || cls == rv32i_pkg::CLS_NONE) ? '0
                                                                          : i_instr[11:7];

  ////////////////////////////////////////////////////////////////////////////
  // decode output register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid & ~i_flush;          // flushed slot never executes
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_class  <= cls;
      o_alu_op <= alu_op;
      o_funct3 <= funct3;
      o_rd     <= rd;
      o_rs1    <= o_rs1_addr;                 // kept for the bypass compare
      o_rs2    <= o_rs2_addr;
      o_imm    <= imm;
      o_pc     <= i_pc;
    end
  end

endmodule

// ==== rtl/rv32i_fetch.sv ====
// fetch stage, keeps the pc and talks to the instruction memory
// one strobe per request, the ack may come back after any delay
// each accepted instruction is handed to decode as a one-cycle strobe
// a redirect from execute moves the pc and drops the reply in flight

`timescale 1ns/100ps

module rv32i_fetch #(
  parameter rv32i_pkg::word_t PC_RESET = '0
) (
  input  logic             i_clk,
  input  logic             i_reset,
  input  rv32i_pkg::word_t i_instr,           // valid with i_instr_ack
  input  logic             i_instr_ack,
  input  logic             i_redirect,        // taken branch or jal in execute
  input  rv32i_pkg::word_t i_target,
  output rv32i_pkg::word_t o_iaddr,
  output logic             o_instr_stb,
  output logic             o_valid,           // to decode
  output rv32i_pkg::word_t o_instr,
  output rv32i_pkg::word_t o_pc
);

  rv32i_pkg::word_t pc;                       // address of current request
  logic             pending;                  // strobe sent, ack not yet seen
  logic             discard;                  // outstanding reply is stale
  logic             drop;                     // this ack goes nowhere

  assign o_iaddr = pc;
  assign drop    = discard | i_redirect;

  ////////////////////////////////////////////////////////////////////////////
  // request control
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc          <= PC_RESET;
      pending     <= 1'b0;
      discard     <= 1'b0;
      o_instr_stb <= 1'b0;
      o_valid     <= 1'b0;
    end else begin
      o_instr_stb <= i_instr_ack | (~o_instr_stb & ~pending);  // first req after reset
      pending     <= (pending & ~i_instr_ack) | o_instr_stb;
      o_valid     <= i_instr_ack & ~drop;
      if (i_redirect) begin
        pc      <= i_target;
        discard <= ~i_instr_ack & (pending | o_instr_stb);     // reply still to come
      end else if (i_instr_ack) begin
        if (!discard) begin
          pc <= pc + 32'd4;                   // sequential fetch
        end
        discard <= 1'b0;                      // stale reply has arrived
      end
    end
  end

  // payload to decode, no reset needed
  always_ff @(posedge i_clk) begin
    if (i_instr_ack) begin
      o_instr <= drop ? rv32i_pkg::NOP_INSTR : i_instr;
      o_pc    <= pc;
    end
  end

  // the memory must not get a second strobe before it has answered
  a_one_outstanding : assert property (@(posedge i_clk) disable iff (i_reset)
    o_instr_stb |-> !pending);

endmodule

// ==== rtl/rv32i_regfile.sv ====
// 32 x 32 base register file with two registered read ports
// reads are taken when i_rd_en is high and appear one cycle later
// a write in the same cycle as a matching read is passed straight through

`timescale 1ns/100ps

module rv32i_regfile (
  input  logic                 i_clk,
  input  logic                 i_rd_en,       // decode has a valid instruction
  input  rv32i_pkg::reg_addr_t i_rs1_addr,
  input  rv32i_pkg::reg_addr_t i_rs2_addr,
  input  logic                 i_we,          // writeback enable from execute
  input  rv32i_pkg::reg_addr_t i_rd,
  input  rv32i_pkg::word_t     i_wdata,
  output rv32i_pkg::word_t     o_rs1_data,
  output rv32i_pkg::word_t     o_rs2_data
);

  rv32i_pkg::word_t regs [32];                // entry 0 is never read

  // x0 is hardwired, then write-through, then the stored value
  function automatic rv32i_pkg::word_t read_port(input rv32i_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (i_we && (addr == i_rd)) begin
      return i_wdata;                         // same-cycle write wins
    end
    return regs[addr];
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      regs[i_rd] <= i_wdata;
    end
    if (i_rd_en) begin
      o_rs1_data <= read_port(i_rs1_addr);    // aligned with decode output reg
      o_rs2_data <= read_port(i_rs2_addr);
    end
  end

  // execute must already have masked writes to x0
  a_no_x0_write : assert property (@(posedge i_clk) i_we |-> (i_rd != '0));

endmodule

// ==== rtl/rv32i_pkg.sv ====
// shared widths, types and encodings for the three-stage RV32I core
// all RTL files refer to these through rv32i_pkg:: scoped names
// the testbench uses word_t and reg_addr_t for its compare tasks

package rv32i_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and basic types
  ////////////////////////////////////////////////////////////////////////////
  localparam int XLEN       = 32;                 // data and address width
  localparam int REG_ADDR_W = 5;                  // 32 base registers

  typedef logic [XLEN-1:0]       word_t;          // data or address word
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;      // register index

  localparam word_t NOP_INSTR = 32'h0000_0013;    // addi x0,x0,0

  ////////////////////////////////////////////////////////////////////////////
  // major opcodes the core understands, anything else retires as a no-op
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,                      // register-register alu
    OPC_OP_IMM = 7'b0010011,                      // register-immediate alu
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,                      // only beq/bne accepted
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // decoded instruction class, drives the execute result mux
  typedef enum logic [2:0] {
    CLS_ALU_REG,
    CLS_ALU_IMM,
    CLS_LUI,
    CLS_BRANCH,
    CLS_JAL,
    CLS_NONE                                      // unsupported, no write
  } op_class_e;

  // alu operations
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU
  } alu_op_e;

endpackage
